/* vdma_defs.svh */
/*
 * video write DMA sizing
 * channel count, pixel and word widths, DDR address width,
 * burst length and per-channel buffer depth
 */
`ifndef VDMA_DEFS_SVH
`define VDMA_DEFS_SVH

// channels in the port array
`define VDMA_NCH            4
// one pixel, 16 bit
`define VDMA_PIX_W          16
`define VDMA_PIX_PER_WORD   4
// DDR native data width
`define VDMA_DATA_W         64
// DDR word address
`define VDMA_ASIZE          27
// words per write burst
`define VDMA_BURST_LEN      4
// words buffered in each channel
`define VDMA_FIFO_DEPTH     8

`endif

/* vdma_pkg.sv */
/*
 * video write DMA types
 * pixel, memory word and DDR address types,
 * DDR native command codes and the arbiter states
 */
`include "vdma_defs.svh"

package vdma_pkg;

    typedef logic [`VDMA_PIX_W-1:0]  pixel_t;
    typedef logic [`VDMA_DATA_W-1:0] word_t;
    typedef logic [`VDMA_ASIZE-1:0]  addr_t;

    // DDR native command field, only writes go out
    typedef enum logic [2:0] {
        CMD_WRITE = 3'd0,
        CMD_READ  = 3'd1
    } ddr_cmd_e;

    // arbiter: waiting for a request or moving one burst
    typedef enum logic {
        ARB_IDLE,
        ARB_BURST
    } arb_state_e;

endpackage

/* vdma_ifs.sv */
/*
 * video write DMA internal interfaces
 * video_frame_if carries the gated pixel stream to a write port,
 * burst_if carries a port's ready bursts to the DDR arbiter
 */
`timescale 1ns/1ps

interface video_frame_if;
    import vdma_pkg::*;

    // one cycle pulse with the first pixel of a frame
    logic   frame_start;
    // burst base for the frame, valid with frame_start
    addr_t  frame_base;
    logic   pix_valid;
    pixel_t pix_data;

    // no back-pressure, video does not stall
    modport src (
        output frame_start, frame_base, pix_valid, pix_data
    );
    modport dst (
        input  frame_start, frame_base, pix_valid, pix_data
    );
endinterface

interface burst_if;
    import vdma_pkg::*;

    // at least one whole burst waiting
    logic  req;
    // address of the burst's first word
    addr_t addr;
    // fifo head word
    word_t data;
    // one pulse per word taken
    logic  pop;

    modport port (
        output req, addr, data,
        input  pop
    );
    modport arb (
        input  req, addr, data,
        output pop
    );
endinterface

/* frame_ctrl.sv */
/*
 * frame gating for the write channels
 * arms a channel on a start of frame seen with calibration done and
 * the channel enabled, latches its base address and forwards pixels
 * one cycle later; pixels of an unarmed channel are dropped
 */
`timescale 1ns/1ps
`include "vdma_defs.svh"

module frame_ctrl (
    input  logic             axi_m00_inf,
    input  logic             reset,
    input  logic             init_calib_complete,
    input  logic [`VDMA_NCH-1:0] ch_enable,
    input  vdma_pkg::addr_t  wr_baseaddr [`VDMA_NCH],
    input  logic [`VDMA_NCH-1:0] pix_sof,
    input  logic [`VDMA_NCH-1:0] pix_valid,
    input  vdma_pkg::pixel_t pix_data [`VDMA_NCH],
    video_frame_if.src       frames [`VDMA_NCH]
);
    import vdma_pkg::*;

    logic [`VDMA_NCH-1:0] armed;
    logic [`VDMA_NCH-1:0] start_q;
    logic [`VDMA_NCH-1:0] valid_q;
    addr_t                base_q [`VDMA_NCH];
    pixel_t               data_q [`VDMA_NCH];

    for (genvar i = 0; i < `VDMA_NCH; i++) begin : g_ch
        // ----------------------------------------
        // arm / disarm on start of frame
        // ----------------------------------------
        always_ff @(posedge axi_m00_inf) begin
            if (reset) begin
                armed[i]   <= 1'b0;
                start_q[i] <= 1'b0;
                valid_q[i] <= 1'b0;
            end else if (pix_valid[i] && pix_sof[i]) begin
                // sof without calibration or enable leaves the channel idle
                armed[i]   <= init_calib_complete && ch_enable[i];
                start_q[i] <= init_calib_complete && ch_enable[i];
                valid_q[i] <= init_calib_complete && ch_enable[i];
            end else begin
                start_q[i] <= 1'b0;
                valid_q[i] <= pix_valid[i] && armed[i];
            end
        end

        // payload registers
        always_ff @(posedge axi_m00_inf) begin
            data_q[i] <= pix_data[i];
            if (pix_valid[i] && pix_sof[i])
                base_q[i] <= wr_baseaddr[i];
        end

        assign frames[i].frame_start = start_q[i];
        assign frames[i].frame_base  = base_q[i];
        assign frames[i].pix_valid   = valid_q[i];
        assign frames[i].pix_data    = data_q[i];
    end

endmodule

/* vdma_write_port.sv */
/*
 * one write channel of the video DMA
 * packs four pixels per word (first pixel low), buffers words in an
 * eight deep fifo and offers them to the arbiter as four word bursts
 * at a running address that restarts at each frame base
 */
`timescale 1ns/1ps
`include "vdma_defs.svh"

module vdma_write_port (
    input  logic          axi_m00_inf,
    input  logic          reset,
    video_frame_if.dst    frame,
    burst_if.port         burst,
    output logic          overflow
);
    import vdma_pkg::*;

    // ----------------------------------------
    // pixel packing
    // ----------------------------------------
    logic [$clog2(`VDMA_PIX_PER_WORD)-1:0] pix_cnt;
    word_t pack;
    word_t packed_word;
    logic  word_done;

    // completed word, last pixel straight from the interface
    always_comb begin
        packed_word = pack;
        packed_word[`VDMA_DATA_W-`VDMA_PIX_W +: `VDMA_PIX_W] = frame.pix_data;
    end

    assign word_done = frame.pix_valid && !frame.frame_start && (&pix_cnt);

    always_ff @(posedge axi_m00_inf) begin
        if (reset)
            pix_cnt <= '0;
        else if (frame.frame_start)
            // first pixel of the frame goes to lane 0
            pix_cnt <= 1;
        else if (frame.pix_valid)
            pix_cnt <= pix_cnt + 1'b1;
    end

    always_ff @(posedge axi_m00_inf) begin
        if (frame.frame_start)
            pack[0 +: `VDMA_PIX_W] <= frame.pix_data;
        else if (frame.pix_valid)
            pack[pix_cnt*`VDMA_PIX_W +: `VDMA_PIX_W] <= frame.pix_data;
    end

    // ----------------------------------------
    // word fifo
    // ----------------------------------------
    word_t mem [`VDMA_FIFO_DEPTH];
    logic [$clog2(`VDMA_FIFO_DEPTH)-1:0] wptr;
    logic [$clog2(`VDMA_FIFO_DEPTH)-1:0] rptr;
    logic [$clog2(`VDMA_FIFO_DEPTH):0]   count;
    logic full;
    logic push;

    assign full = (count == `VDMA_FIFO_DEPTH);
    // full fifo drops the new word
    assign push = word_done && !full;

    always_ff @(posedge axi_m00_inf) begin
        if (push)
            mem[wptr] <= packed_word;
    end

    always_ff @(posedge axi_m00_inf) begin
        if (reset) begin
            wptr     <= '0;
            rptr     <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push)
                wptr <= wptr + 1'b1;
            if (burst.pop)
                rptr <= rptr + 1'b1;
            case ({push, burst.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset
            if (word_done && full)
                overflow <= 1'b1;
        end
    end

    // ----------------------------------------
    // burst address
    // ----------------------------------------
    logic [$clog2(`VDMA_BURST_LEN)-1:0] beat;
    addr_t next_addr;

    always_ff @(posedge axi_m00_inf) begin
        if (reset) begin
            beat      <= '0;
            next_addr <= '0;
        end else begin
            if (burst.pop)
                beat <= beat + 1'b1;
            if (frame.frame_start)
                next_addr <= frame.frame_base;
            else if (burst.pop && (&beat))
                // last word of a burst taken
                next_addr <= next_addr + addr_t'(`VDMA_BURST_LEN);
        end
    end

    assign burst.req  = (count >= `VDMA_BURST_LEN);
    assign burst.addr = next_addr;
    assign burst.data = mem[rptr];

endmodule

/* ddr_write_arbiter.sv */
/*
 * round-robin DDR write arbiter
 * grants one channel at a time for a whole four word burst and drives
 * the DDR native command and write data ports, holding everything
 * while app_rdy or app_wdf_rdy is low
 */
`timescale 1ns/1ps
`include "vdma_defs.svh"

module ddr_write_arbiter (
    input  logic               axi_m00_inf,
    input  logic               reset,
    burst_if.arb               bursts [`VDMA_NCH],
    output vdma_pkg::addr_t    app_addr,
    output vdma_pkg::ddr_cmd_e app_cmd,
    output logic               app_en,
    output vdma_pkg::word_t    app_wdf_data,
    output logic               app_wdf_end,
    output logic [`VDMA_DATA_W/8-1:0] app_wdf_mask,
    output logic               app_wdf_wren,
    input  logic               app_rdy,
    input  logic               app_wdf_rdy
);
    import vdma_pkg::*;

    typedef logic [$clog2(`VDMA_NCH)-1:0] ch_t;

    arb_state_e state;
    ch_t        grant;
    ch_t        last_grant;
    ch_t        next_grant;
    logic       found;
    logic       accept;
    addr_t      cur_addr;
    logic [$clog2(`VDMA_BURST_LEN)-1:0] beat;

    logic [`VDMA_NCH-1:0] req_v;
    addr_t head_addr [`VDMA_NCH];
    word_t head_data [`VDMA_NCH];

    // word taken by the DDR controller this cycle
    assign accept = (state == ARB_BURST) && app_rdy && app_wdf_rdy;

    for (genvar i = 0; i < `VDMA_NCH; i++) begin : g_tap
        assign req_v[i]       = bursts[i].req;
        assign head_addr[i]   = bursts[i].addr;
        assign head_data[i]   = bursts[i].data;
        assign bursts[i].pop  = accept && (grant == ch_t'(i));
    end

    // ----------------------------------------
    // round-robin search
    // ----------------------------------------
    always_comb begin
        ch_t idx;
        found      = 1'b0;
        next_grant = last_grant;
        // start one past the last winner, wrap around
        for (int k = 1; k <= `VDMA_NCH; k++) begin
            idx = last_grant + ch_t'(k);
            if (!found && req_v[idx]) begin
                found      = 1'b1;
                next_grant = idx;
            end
        end
    end

    // ----------------------------------------
    // burst FSM
    // ----------------------------------------
    always_ff @(posedge axi_m00_inf) begin
        if (reset) begin
            state      <= ARB_IDLE;
            grant      <= '0;
            last_grant <= ch_t'(`VDMA_NCH - 1);
            beat       <= '0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        state <= ARB_BURST;
                        grant <= next_grant;
                        beat  <= '0;
                    end
                end
                ARB_BURST: begin
                    if (accept) begin
                        beat <= beat + 1'b1;
                        // whole burst out, next grant may go elsewhere
                        if (&beat) begin
                            state      <= ARB_IDLE;
                            last_grant <= grant;
                        end
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // running word address inside the burst
    always_ff @(posedge axi_m00_inf) begin
        if (state == ARB_IDLE && found)
            cur_addr <= head_addr[next_grant];
        else if (accept)
            cur_addr <= cur_addr + addr_t'(1);
    end

    // command and data go together on every word
    assign app_en       = (state == ARB_BURST);
    assign app_wdf_wren = app_en;
    assign app_wdf_end  = app_en;
    assign app_cmd      = CMD_WRITE;
    assign app_addr     = cur_addr;
    assign app_wdf_data = head_data[grant];
    assign app_wdf_mask = '0;

endmodule

/* multiport_vdma_top.sv */
/*
 * four channel video write DMA
 * frame gating feeds one write port per channel, the ports are
 * drained by a round-robin arbiter onto the DDR native interface
 */
`timescale 1ns/1ps
`include "vdma_defs.svh"

module multiport_vdma_top (
    input  logic                 axi_m00_inf,
    input  logic                 reset,
    input  logic                 init_calib_complete,
    // per channel video inputs
    input  logic [`VDMA_NCH-1:0] ch_enable,
    input  vdma_pkg::addr_t      wr_baseaddr [`VDMA_NCH],
    input  logic [`VDMA_NCH-1:0] pix_sof,
    input  logic [`VDMA_NCH-1:0] pix_valid,
    input  vdma_pkg::pixel_t     pix_data [`VDMA_NCH],
    output logic [`VDMA_NCH-1:0] ch_overflow,
    // DDR native write side
    output logic [`VDMA_ASIZE-1:0]    app_addr,
    output logic [2:0]                app_cmd,
    output logic                      app_en,
    output logic [`VDMA_DATA_W-1:0]   app_wdf_data,
    output logic                      app_wdf_end,
    output logic [`VDMA_DATA_W/8-1:0] app_wdf_mask,
    output logic                      app_wdf_wren,
    input  logic                      app_rdy,
    input  logic                      app_wdf_rdy
);

    video_frame_if frames [`VDMA_NCH] ();
    burst_if       bursts [`VDMA_NCH] ();

    frame_ctrl frame_ctrl_inst (
        .axi_m00_inf         (axi_m00_inf),
        .reset               (reset),
        .init_calib_complete (init_calib_complete),
        .ch_enable           (ch_enable),
        .wr_baseaddr         (wr_baseaddr),
        .pix_sof             (pix_sof),
        .pix_valid           (pix_valid),
        .pix_data            (pix_data),
        .frames              (frames)
    );

    // one write port per channel
    for (genvar i = 0; i < `VDMA_NCH; i++) begin : g_port
        vdma_write_port vdma_write_port_inst (
            .axi_m00_inf (axi_m00_inf),
            .reset       (reset),
            .frame       (frames[i]),
            .burst       (bursts[i]),
            .overflow    (ch_overflow[i])
        );
    end

    ddr_write_arbiter ddr_write_arbiter_inst (
        .axi_m00_inf  (axi_m00_inf),
        .reset        (reset),
        .bursts       (bursts),
        .app_addr     (app_addr),
        .app_cmd      (app_cmd),
        .app_en       (app_en),
        .app_wdf_data (app_wdf_data),
        .app_wdf_end  (app_wdf_end),
        .app_wdf_mask (app_wdf_mask),
        .app_wdf_wren (app_wdf_wren),
        .app_rdy      (app_rdy),
        .app_wdf_rdy  (app_wdf_rdy)
    );

endmodule

/* vdma_properties.sv */
/*
 * DDR write side properties of the video DMA
 * command and write strobe move together, outputs hold under
 * back-pressure and only write commands go out
 */
`timescale 1ns/1ps
`include "vdma_defs.svh"

module vdma_properties (
    input logic                    axi_m00_inf,
    input logic                    reset,
    input logic [`VDMA_ASIZE-1:0]  app_addr,
    input logic [2:0]              app_cmd,
    input logic                    app_en,
    input logic [`VDMA_DATA_W-1:0] app_wdf_data,
    input logic                    app_wdf_wren,
    input logic                    app_rdy,
    input logic                    app_wdf_rdy
);
    import vdma_pkg::*;

    // command and data strobe go together
    wren_follows_en: assert property (@(posedge axi_m00_inf) disable iff (reset)
        app_wdf_wren == app_en)
        else $error("app_wdf_wren differs from app_en");

    // stalled word stays put until taken
    hold_when_stalled: assert property (@(posedge axi_m00_inf) disable iff (reset)
        app_en && !(app_rdy && app_wdf_rdy) |=>
            app_en && $stable(app_addr) && $stable(app_wdf_data))
        else $error("DDR outputs changed under back-pressure");

    write_cmd_only: assert property (@(posedge axi_m00_inf) disable iff (reset)
        app_cmd == CMD_WRITE)
        else $error("app_cmd is not a write command");

endmodule

bind multiport_vdma_top vdma_properties vdma_properties_inst (
    .axi_m00_inf  (axi_m00_inf),
    .reset        (reset),
    .app_addr     (app_addr),
    .app_cmd      (app_cmd),
    .app_en       (app_en),
    .app_wdf_data (app_wdf_data),
    .app_wdf_wren (app_wdf_wren),
    .app_rdy      (app_rdy),
    .app_wdf_rdy  (app_wdf_rdy)
);

/* tb_multiport_vdma.sv */
/*
 * testbench for the four channel video write DMA
 * random DDR ready model, table of frames run in groups,
 * capture of every accepted DDR write and word by word checks
 */
`timescale 1ns/1ps
`include "vdma_defs.svh"

module tb_multiport_vdma;
    import vdma_pkg::*;

    localparam int NROWS = 10;
    localparam int NGRP  = 6;
    // cycles from one pixel to the next on a channel
    localparam int GAP   = 6;

    typedef struct packed {
        int     grp;
        int     ch;
        addr_t  base;
        int     npix;
        pixel_t first;
        int     rdy_pct;
        logic   en;
        logic   cal;
        logic   ovf;
    } row_t;

    logic                      axi_m00_inf;
    logic                      reset;
    logic                      init_calib_complete;
    logic [`VDMA_NCH-1:0]      ch_enable;
    logic [`VDMA_NCH-1:0]      pix_sof;
    logic [`VDMA_NCH-1:0]      pix_valid;
    logic [`VDMA_NCH-1:0]      ch_overflow;
    addr_t                     wr_baseaddr [`VDMA_NCH];
    pixel_t                    pix_data [`VDMA_NCH];
    addr_t                     app_addr;
    logic [2:0]                app_cmd;
    logic                      app_en;
    word_t                     app_wdf_data;
    logic                      app_wdf_end;
    logic [`VDMA_DATA_W/8-1:0] app_wdf_mask;
    logic                      app_wdf_wren;
    logic                      app_rdy;
    logic                      app_wdf_rdy;

    string grp_name [NGRP] = '{"single_frame", "new_frame", "all_channels",
                               "disabled_channel", "calib_low", "overflow"};

    // grp, ch, base, pixels, first pixel, ready %, enable, calib, overflow
    row_t rows [NROWS] = '{
        '{0, 0, 27'h100, 64, 16'h1000, 100, 1'b1, 1'b1, 1'b0},
        '{1, 0, 27'h400, 32, 16'h2000,  90, 1'b1, 1'b1, 1'b0},
        '{2, 0, 27'h800, 64, 16'h3000,  70, 1'b1, 1'b1, 1'b0},
        '{2, 1, 27'h900, 64, 16'h4000,  70, 1'b1, 1'b1, 1'b0},
        '{2, 2, 27'hA00, 64, 16'h5000,  70, 1'b1, 1'b1, 1'b0},
        '{2, 3, 27'hB00, 64, 16'h6000,  70, 1'b1, 1'b1, 1'b0},
        '{3, 1, 27'hC00, 32, 16'h7000,  80, 1'b0, 1'b1, 1'b0},
        '{3, 2, 27'hD00, 32, 16'h7100,  80, 1'b1, 1'b1, 1'b0},
        '{4, 3, 27'hE00, 32, 16'h8000,  80, 1'b1, 1'b0, 1'b0},
        '{5, 2, 27'hF00, 40, 16'h9000,   0, 1'b1, 1'b1, 1'b1}
    };

    word_t memory [addr_t];
    word_t expected [addr_t];
    addr_t last_addr;
    string cur_test    = "startup";
    int    n_written   = 0;
    int    rdy_pct     = 100;
    int    cycles      = 0;
    int    cycle_limit = 2000;

    initial begin
        axi_m00_inf = 1'b0;
        forever #2 axi_m00_inf = ~axi_m00_inf;
    end

    multiport_vdma_top UUT (.*);

    // ----------------------------------------
    // reporting
    // ----------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            stop_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_run($sformatf("FAIL %s expected %b actual %b", name, exp, act));
    endtask

    // ----------------------------------------
    // DDR model and write capture
    // ----------------------------------------
    initial begin : ddr_model
        app_rdy     = 1'b0;
        app_wdf_rdy = 1'b0;
        void'($urandom(17738));
        forever begin
            @(negedge axi_m00_inf);
            app_rdy     = ($urandom % 100) < rdy_pct;
            app_wdf_rdy = ($urandom % 100) < rdy_pct;
        end
    end

    always @(posedge axi_m00_inf) begin
        if (!reset && app_en && app_wdf_wren && app_rdy && app_wdf_rdy) begin
            if (memory.exists(app_addr))
                stop_run($sformatf("address %h was written twice", app_addr));
            // four writes of one burst go to consecutive addresses
            if (n_written % 4 != 0 && app_addr != last_addr + 1'b1)
                stop_run($sformatf("burst address jumped to %h", app_addr));
            check_flag($sformatf("%s wdf_end", cur_test), 1'b1, app_wdf_end);
            check_flag($sformatf("%s wdf_mask_clear", cur_test), 1'b1, app_wdf_mask == '0);
            memory[app_addr] = app_wdf_data;
            last_addr = app_addr;
            n_written++;
        end
    end

    always @(posedge axi_m00_inf) begin
        cycles++;
        if (cycles > cycle_limit)
            stop_run("timeout, the DMA did not finish its writes in time");
    end

    // words of one frame, first pixel in the low lane
    task automatic add_expected(input row_t row);
        int    k;
        int    q;
        word_t w;
        for (k = 0; k < row.npix / `VDMA_PIX_PER_WORD; k++) begin
            for (q = 0; q < `VDMA_PIX_PER_WORD; q++)
                w[q*`VDMA_PIX_W +: `VDMA_PIX_W] = row.first + pixel_t'(4*k + q);
            expected[row.base + addr_t'(k)] = w;
        end
    endtask

    // ----------------------------------------
    // one group of rows, driven side by side
    // ----------------------------------------
    task automatic run_group(input int g);
        int                   r;
        int                   j;
        int                   k;
        int                   maxpix;
        addr_t                a;
        logic [`VDMA_NCH-1:0] ovf_exp;
        maxpix   = 0;
        ovf_exp  = '0;
        cur_test = grp_name[g];
        @(negedge axi_m00_inf);
        for (r = 0; r < NROWS; r++) begin
            if (rows[r].grp == g) begin
                ch_enable[rows[r].ch]   = rows[r].en;
                wr_baseaddr[rows[r].ch] = rows[r].base;
                init_calib_complete     = rows[r].cal;
                rdy_pct                 = rows[r].rdy_pct;
                ovf_exp[rows[r].ch]     = rows[r].ovf;
                if (rows[r].npix > maxpix)
                    maxpix = rows[r].npix;
                // only gated-in frames with a live DDR side reach memory
                if (rows[r].en && rows[r].cal && rows[r].rdy_pct > 0)
                    add_expected(rows[r]);
            end
        end
        for (j = 0; j < maxpix; j++) begin
            for (r = 0; r < NROWS; r++) begin
                if (rows[r].grp == g && j < rows[r].npix) begin
                    pix_valid[rows[r].ch] = 1'b1;
                    pix_sof[rows[r].ch]   = (j == 0);
                    pix_data[rows[r].ch]  = rows[r].first + pixel_t'(j);
                end
            end
            @(negedge axi_m00_inf);
            pix_valid = '0;
            pix_sof   = '0;
            repeat (GAP - 1) @(negedge axi_m00_inf);
        end
        while (n_written < expected.num())
            @(posedge axi_m00_inf);
        // quiet time to catch stray writes
        repeat (32) @(posedge axi_m00_inf);
        if (n_written != expected.num())
            stop_run($sformatf("%s wrote %0d words, %0d expected",
                               grp_name[g], n_written, expected.num()));
        for (r = 0; r < NROWS; r++) begin
            if (rows[r].grp == g && rows[r].en && rows[r].cal && rows[r].rdy_pct > 0) begin
                for (k = 0; k < rows[r].npix / `VDMA_PIX_PER_WORD; k++) begin
                    a = rows[r].base + addr_t'(k);
                    if (!memory.exists(a))
                        stop_run($sformatf("%s has no write at %h", grp_name[g], a));
                    check_word(grp_name[g], expected[a], memory[a]);
                end
            end
        end
        for (k = 0; k < `VDMA_NCH; k++)
            check_flag($sformatf("%s ch_overflow[%0d]", grp_name[g], k),
                       ovf_exp[k], ch_overflow[k]);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin : stimulus
        int r;
        int g;
        int c;
        for (r = 0; r < NROWS; r++)
            cycle_limit += 20 * rows[r].npix;
        reset               = 1'b1;
        init_calib_complete = 1'b0;
        ch_enable           = '0;
        pix_sof             = '0;
        pix_valid           = '0;
        for (c = 0; c < `VDMA_NCH; c++) begin
            wr_baseaddr[c] = '0;
            pix_data[c]    = '0;
        end
        repeat (4) @(posedge axi_m00_inf);
        @(negedge axi_m00_inf);
        reset = 1'b0;
        for (g = 0; g < NGRP; g++)
            run_group(g);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* all.f */
+incdir+.
vdma_pkg.sv
vdma_ifs.sv
frame_ctrl.sv
vdma_write_port.sv
ddr_write_arbiter.sv
multiport_vdma_top.sv
vdma_properties.sv
tb_multiport_vdma.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_multiport_vdma
FILELIST  = all.f
PASS_MSG  = All tests passed!

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
